// ==== design/minx_pkg.sv ====
package minx_pkg;

    // Bus cycle kind, same 2-bit field as the core's bus_status
    typedef enum logic [1:0] {
        BUS_IDLE        = 2'd0,
        BUS_MEM_READ    = 2'd1,
        BUS_MEM_WRITE   = 2'd2,
        BUS_VECTOR_READ = 2'd3
    } bus_status_t;

    // Register window
    localparam logic [23:0] REG_BASE   = 24'h00_2080;
    localparam logic [23:0] REG_LAST   = 24'h00_20FF;
    localparam logic [23:0] COPY_BASE  = 24'h00_2080;
    localparam logic [23:0] TIMER_BASE = 24'h00_20A0; // Four bytes per timer

    localparam int MAX_TIMERS = 8;

    // Timer register offsets
    localparam logic [1:0] TMR_RELOAD = 2'd0;
    localparam logic [1:0] TMR_COUNT  = 2'd1;
    localparam logic [1:0] TMR_CTRL   = 2'd2;

    // Copy engine register offsets
    localparam logic [1:0] COPY_SRC  = 2'd0; // Byte picked by the index in control
    localparam logic [1:0] COPY_DST  = 2'd1;
    localparam logic [1:0] COPY_LEN  = 2'd2;
    localparam logic [1:0] COPY_CTRL = 2'd3;

    localparam int CTRL_START = 0;
    localparam int CTRL_CLEAR = 1;

    // One register access as seen by a block
    typedef struct packed {
        logic       sel;
        logic       wr;
        logic [1:0] offset;
        logic [7:0] wdata;
    } reg_access_t;

    // What one master drives onto the system bus
    typedef struct packed {
        logic [23:0] address;
        logic [7:0]  data;
        logic        read;
        logic        write;
        bus_status_t status;
    } bus_t;

endpackage

// ==== design/reg_decode.sv ====
module reg_decode #(
    parameter int NUM_TIMERS = 3
) (
    input  minx_pkg::bus_t        bus,
    output logic                  reg_hit,
    output minx_pkg::reg_access_t copy_acc,
    output minx_pkg::reg_access_t timer_acc [NUM_TIMERS]
);
    import minx_pkg::*;

    localparam int IDX_W = $clog2(MAX_TIMERS);
    localparam logic [23:0] TIMER_LAST = TIMER_BASE + 24'(4 * MAX_TIMERS - 1);

    logic             is_wr;
    logic             copy_hit;
    logic             timer_hit;
    logic [IDX_W-1:0] timer_idx;

    assign is_wr = bus.write && (bus.status == BUS_MEM_WRITE);

    // Whole window, unmapped bytes read back as zero
    assign reg_hit = (bus.address >= REG_BASE) && (bus.address <= REG_LAST);

    assign copy_hit  = (bus.address[23:2] == COPY_BASE[23:2]);
    assign timer_hit = (bus.address >= TIMER_BASE) && (bus.address <= TIMER_LAST);
    assign timer_idx = bus.address[IDX_W+1:2]; // TIMER_BASE is slot aligned

    always_comb begin
        copy_acc = '{
            sel:    copy_hit,
            wr:     copy_hit && is_wr,
            offset: bus.address[1:0],
            wdata:  bus.data
        };
    end

    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            timer_acc[i].sel    = timer_hit && (timer_idx == IDX_W'(i));
            timer_acc[i].wr     = timer_hit && (timer_idx == IDX_W'(i)) && is_wr;
            timer_acc[i].offset = bus.address[1:0];
            timer_acc[i].wdata  = bus.data;
        end
    end

endmodule

// ==== design/timer_channel.sv ====
module timer_channel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  minx_pkg::reg_access_t acc,
    output logic [7:0]            rdata,
    output logic                  irq
);
    import minx_pkg::*;

    logic [7:0] reload;
    logic [7:0] count;
    logic       enable;
    logic       flag;
    logic       wr_reload;
    logic       wr_ctrl;

    assign wr_reload = acc.sel && acc.wr && (acc.offset == TMR_RELOAD);
    assign wr_ctrl   = acc.sel && acc.wr && (acc.offset == TMR_CTRL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload <= '0;
            count  <= '0;
            enable <= 1'b0;
            flag   <= 1'b0;
        end else begin
            if (wr_reload)
                reload <= acc.wdata;
            if (wr_ctrl) begin
                enable <= acc.wdata[0];
                if (acc.wdata[7])
                    flag <= 1'b0; // Write one to clear
            end

            // Count tracks reload while stopped, so it starts from R
            if (!enable) begin
                count <= wr_reload ? acc.wdata : reload;
            end else if (count == 8'd0) begin
                count <= reload;
                flag  <= 1'b1;
            end else begin
                count <= count - 8'd1;
            end
        end
    end

    always_comb begin
        rdata = 8'h00;
        if (acc.sel) begin
            case (acc.offset)
                TMR_RELOAD: rdata = reload;
                TMR_COUNT:  rdata = count;
                TMR_CTRL:   rdata = {flag, 6'b0, enable};
                default:    rdata = 8'h00;
            endcase
        end
    end

    assign irq = flag;

endmodule

// ==== design/periph_collect.sv ====
module periph_collect #(
    parameter int NUM_TIMERS = 3
) (
    input  logic [7:0]            copy_rdata,
    input  logic [7:0]            timer_rdata [NUM_TIMERS],
    input  logic                  copy_irq,
    input  logic [NUM_TIMERS-1:0] timer_irq,
    output logic [7:0]            reg_rdata,
    output logic [NUM_TIMERS:0]   irq
);

    // Unselected blocks return zero, so a plain OR merges them
    always_comb begin
        reg_rdata = copy_rdata;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            reg_rdata = reg_rdata | timer_rdata[i];
        end
    end

    // Bit 0 copy done, timers above it
    assign irq = {timer_irq, copy_irq};

endmodule

// ==== design/copy_engine.sv ====
module copy_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  minx_pkg::reg_access_t acc,
    input  logic [7:0]            bus_data_in,
    input  logic                  bus_ack,
    output minx_pkg::bus_t        dma_bus,
    output logic                  bus_request,
    output logic [7:0]            rdata,
    output logic                  irq_copy_done
);
    import minx_pkg::*;

    typedef enum logic {
        PH_READ,
        PH_WRITE
    } phase_t;

    logic [23:0] src;
    logic [23:0] dst;
    logic [7:0]  len;
    logic [1:0]  byte_idx;
    logic        busy;
    logic        done;
    phase_t      phase;
    logic [7:0]  data_buf;
    logic        xfer;
    logic        reg_wr;

    function automatic logic [23:0] put_byte(input logic [23:0] word, input logic [1:0] idx,
                                             input logic [7:0] value);
        logic [23:0] res;
        res = word;
        case (idx)
            2'd0:    res[7:0]   = value;
            2'd1:    res[15:8]  = value;
            2'd2:    res[23:16] = value;
            default: res = word;
        endcase
        return res;
    endfunction

    function automatic logic [7:0] get_byte(input logic [23:0] word, input logic [1:0] idx);
        logic [7:0] res;
        res = 8'h00;
        if (idx != 2'd3)
            res = word[idx*8 +: 8];
        return res;
    endfunction

    assign xfer   = busy && bus_ack; // No bus cycle without the grant
    assign reg_wr = acc.sel && acc.wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src      <= '0;
            dst      <= '0;
            len      <= '0;
            byte_idx <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            phase    <= PH_READ;
        end else begin
            if (reg_wr) begin
                case (acc.offset)
                    COPY_SRC: if (!busy) src <= put_byte(src, byte_idx, acc.wdata);
                    COPY_DST: if (!busy) dst <= put_byte(dst, byte_idx, acc.wdata);
                    COPY_LEN: if (!busy) len <= acc.wdata;
                    default: begin
                        byte_idx <= acc.wdata[5:4];
                        if (acc.wdata[CTRL_CLEAR])
                            done <= 1'b0;
                        if (acc.wdata[CTRL_START] && !busy) begin
                            phase <= PH_READ;
                            done  <= (len == 8'd0); // Empty copy finishes at once
                            busy  <= (len != 8'd0);
                        end
                    end
                endcase
            end

            if (xfer) begin
                if (phase == PH_READ) begin
                    phase <= PH_WRITE;
                end else begin
                    phase <= PH_READ;
                    src   <= src + 24'd1;
                    dst   <= dst + 24'd1;
                    len   <= len - 8'd1;
                    if (len == 8'd1) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && phase == PH_READ)
            data_buf <= bus_data_in; // Sampled at end of read cycle
    end

    always_comb begin
        dma_bus = '{address: '0, data: '0, read: 1'b0, write: 1'b0, status: BUS_IDLE};
        if (xfer) begin
            if (phase == PH_READ) begin
                dma_bus.address = src;
                dma_bus.read    = 1'b1;
                dma_bus.status  = BUS_MEM_READ;
            end else begin
                dma_bus.address = dst;
                dma_bus.data    = data_buf;
                dma_bus.write   = 1'b1;
                dma_bus.status  = BUS_MEM_WRITE;
            end
        end
    end

    always_comb begin
        rdata = 8'h00;
        if (acc.sel) begin
            case (acc.offset)
                COPY_SRC: rdata = get_byte(src, byte_idx);
                COPY_DST: rdata = get_byte(dst, byte_idx);
                COPY_LEN: rdata = len;
                default:  rdata = {2'b0, byte_idx, 2'b0, done, busy};
            endcase
        end
    end

    assign bus_request   = busy;
    assign irq_copy_done = done;

endmodule

// ==== design/minx_soc.sv ====
module minx_soc #(
    parameter int NUM_TIMERS = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            data_in,
    input  minx_pkg::bus_t        cpu_bus,
    input  logic                  bus_ack,
    output logic [7:0]            data_out,
    output logic [23:0]           address_out,
    output logic                  read,
    output logic                  write,
    output minx_pkg::bus_status_t bus_status,
    output logic [7:0]            cpu_data_in,
    output logic                  bus_request,
    output logic [NUM_TIMERS:0]   irq
);
    import minx_pkg::*;

    bus_t                  dma_bus;
    bus_t                  active_bus;
    logic                  reg_hit;
    reg_access_t           copy_acc;
    reg_access_t           timer_acc [NUM_TIMERS];
    logic [7:0]            copy_rdata;
    logic [7:0]            timer_rdata [NUM_TIMERS];
    logic                  copy_irq;
    logic [NUM_TIMERS-1:0] timer_irq;
    logic [7:0]            reg_rdata;

    // DMA owns the bus for as long as the grant is held
    assign active_bus = bus_ack ? dma_bus : cpu_bus;

    assign data_out    = active_bus.data;
    assign address_out = active_bus.address;
    assign read        = active_bus.read;
    assign write       = active_bus.write;
    assign bus_status  = active_bus.status;

    assign cpu_data_in = (reg_hit && active_bus.status == BUS_MEM_READ) ? reg_rdata : data_in;

    reg_decode #(
        .NUM_TIMERS (NUM_TIMERS)
    ) i_reg_decode (
        .bus       (active_bus),
        .reg_hit   (reg_hit),
        .copy_acc  (copy_acc),
        .timer_acc (timer_acc)
    );

    copy_engine i_copy_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc           (copy_acc),
        .bus_data_in   (data_in),
        .bus_ack       (bus_ack),
        .dma_bus       (dma_bus),
        .bus_request   (bus_request),
        .rdata         (copy_rdata),
        .irq_copy_done (copy_irq)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        timer_channel i_timer (
            .clk   (clk),
            .rst_n (rst_n),
            .acc   (timer_acc[i]),
            .rdata (timer_rdata[i]),
            .irq   (timer_irq[i])
        );
    end

    periph_collect #(
        .NUM_TIMERS (NUM_TIMERS)
    ) i_periph_collect (
        .copy_rdata  (copy_rdata),
        .timer_rdata (timer_rdata),
        .copy_irq    (copy_irq),
        .timer_irq   (timer_irq),
        .reg_rdata   (reg_rdata),
        .irq         (irq)
    );

endmodule

// ==== tests/tb_minx_soc.sv ====
module tb_minx_soc;
    timeunit 1ns;
    timeprecision 1ps;
    import minx_pkg::*;

    localparam int NUM_TIMERS = 3;
    localparam int TMR_R = 5; // Reload for the period test
    localparam logic [23:0] LEN_A  = COPY_BASE + 24'(COPY_LEN);
    localparam logic [23:0] CTRL_A = COPY_BASE + 24'(COPY_CTRL);

    logic                clk = 1'b0;
    logic                rst_n;
    logic [7:0]          data_in;
    bus_t                cpu_bus;
    logic                bus_ack;
    logic [7:0]          data_out;
    logic [23:0]         address_out;
    logic                read;
    logic                write;
    bus_status_t         bus_status;
    logic [7:0]          cpu_data_in;
    logic                bus_request;
    logic [NUM_TIMERS:0] irq;

    logic [7:0]  mem [65536];
    logic [31:0] rng = 32'h1ddc_5237;
    bit          ack_random;
    bit          idle_chk;
    bit          tmr_go;
    bit          tmr_phase;
    bit          clr_go;
    bit          zero_phase;
    bit          done_clr_go;
    int          act_cnt;
    int          req_cnt;
    int          stall_cnt;
    int          error_count;
    int          test_num;
    int          test_fails;
    int          test_base;

    minx_soc #(
        .NUM_TIMERS (NUM_TIMERS)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .cpu_bus     (cpu_bus),
        .bus_ack     (bus_ack),
        .data_out    (data_out),
        .address_out (address_out),
        .read        (read),
        .write       (write),
        .bus_status  (bus_status),
        .cpu_data_in (cpu_data_in),
        .bus_request (bus_request),
        .irq         (irq)
    );

    always #50 clk = ~clk;

    // 64 KB external memory
    assign data_in = mem[address_out[15:0]];

    always @(posedge clk) begin
        if (write)
            mem[address_out[15:0]] <= data_out;
        if (read || write)
            act_cnt <= act_cnt + 1;
        if (bus_request)
            req_cnt <= req_cnt + 1;
        if (bus_request && !bus_ack)
            stall_cnt <= stall_cnt + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Grant follows the request and drops at random when enabled
    always @(posedge clk) begin
        #10;
        if (ack_random) begin
            rng = xorshift(rng);
            bus_ack = bus_request && (rng[1:0] != 2'b00);
        end else begin
            bus_ack = bus_request;
        end
    end

    task automatic log_error(input string msg);
        $display("error %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic wait_irq(input int bit_idx, input int limit, input string what);
        int n;
        n = 0;
        while (!irq[bit_idx]) begin
            if (n == limit)
                abort_run({"Timed out waiting for ", what});
            @(posedge clk);
            #10;
            n++;
        end
    endtask

    task automatic cpu_write(input logic [23:0] addr, input logic [7:0] d);
        cpu_bus = '{address: addr, data: d, read: 1'b0, write: 1'b1, status: BUS_MEM_WRITE};
        @(posedge clk);
        #10;
        cpu_bus = '0; // Idle status
    endtask

    task automatic cpu_read(input logic [23:0] addr, output logic [7:0] d);
        cpu_bus = '{address: addr, data: 8'h00, read: 1'b1, write: 1'b0, status: BUS_MEM_READ};
        #40;
        d = cpu_data_in; // Mid-cycle sample
        @(posedge clk);
        #10;
        cpu_bus = '0;
    endtask

    task automatic check_reg(input logic [23:0] addr, input logic [7:0] exp, input string what);
        logic [7:0] got;
        cpu_read(addr, got);
        assert (got === exp)
            else log_error($sformatf("%s read %02h, expected %02h", what, got, exp));
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (error_count == test_base) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            test_fails++;
            $display("test %0d %s: FAIL, %0d errors", test_num, name, error_count - test_base);
        end
        test_base = error_count;
    endtask

    task automatic run_copy(input logic [15:0] src, input logic [15:0] dst, input int n,
                            input bit random_ack);
        logic [7:0] expected [$];
        int         limit;
        for (int k = 0; k < n; k++)
            expected.push_back(mem[src + k]);
        limit = random_ack ? 20 * n + 100 : 4 * n + 20;
        for (int k = 0; k < 3; k++) begin
            cpu_write(CTRL_A, 8'(k << 4)); // Byte index
            cpu_write(COPY_BASE, k == 2 ? 8'h00 : src[k*8 +: 8]);
            cpu_write(COPY_BASE + 24'd1, k == 2 ? 8'h00 : dst[k*8 +: 8]);
        end
        cpu_write(LEN_A, 8'(n));
        ack_random = random_ack;
        cpu_write(CTRL_A, 8'h01);
        act_cnt   = 0;
        req_cnt   = 0;
        stall_cnt = 0;
        wait_irq(0, limit, "copy done");
        assert (!bus_request) else log_error("bus_request still high after copy");
        assert (act_cnt == 2 * n)
            else log_error($sformatf("%0d bus cycles, expected %0d", act_cnt, 2 * n));
        if (!random_ack) begin
            assert (req_cnt == 2 * n)
                else log_error($sformatf("copy took %0d cycles, expected %0d", req_cnt, 2 * n));
        end else begin
            assert (stall_cnt > 0) else log_error("bus_ack was never dropped during the copy");
        end
        for (int k = 0; k < n; k++) begin
            assert (mem[dst + k] === expected[k])
                else log_error($sformatf("dst byte %0d is %02h, expected %02h",
                                         k, mem[dst + k], expected[k]));
        end
        ack_random = 1'b0;
    endtask

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> !bus_request && !read && !write && irq == '0 && bus_status == BUS_IDLE)
        else log_error("outputs not idle after reset");

    a_no_cycle_without_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_request && !bus_ack) |-> !(read || write))
        else log_error("bus cycle while bus_ack is low");

    a_one_dma_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_request && bus_ack) |->
            (read != write) && (bus_status == (read ? BUS_MEM_READ : BUS_MEM_WRITE)))
        else log_error("DMA cycle is not a single read or write with matching status");

    a_timer_period: assert property (@(posedge clk) disable iff (!rst_n)
        tmr_go |-> ##(TMR_R + 1) !irq[2] ##1 irq[2])
        else log_error("timer 1 interrupt not at reload plus one cycles");

    a_timer_others: assert property (@(posedge clk) disable iff (!rst_n)
        tmr_phase |-> !irq[0] && !irq[1] && !irq[3])
        else log_error("interrupt from an idle block");

    a_timer_clear: assert property (@(posedge clk) disable iff (!rst_n)
        clr_go |=> !irq[2])
        else log_error("timer 1 interrupt not cleared");

    a_zero_no_request: assert property (@(posedge clk) disable iff (!rst_n)
        zero_phase |-> !bus_request)
        else log_error("bus_request raised for an empty copy");

    a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
        done_clr_go |=> !irq[0])
        else log_error("copy done not cleared");

    initial begin
        rst_n   = 1'b0;
        cpu_bus = '0;
        bus_ack = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            rng    = xorshift(rng);
            mem[a] = rng[7:0];
        end
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;

        idle_chk = 1'b1;
        wait_cycles(3);
        idle_chk = 1'b0;
        end_test("reset state");

        cpu_write(TIMER_BASE, 8'h3c);
        check_reg(TIMER_BASE, 8'h3c, "timer 0 reload");
        check_reg(TIMER_BASE + 24'd1, 8'h3c, "timer 0 count");
        cpu_write(LEN_A, 8'h2a);
        check_reg(LEN_A, 8'h2a, "copy length");
        end_test("register readback");

        tmr_phase = 1'b1;
        cpu_write(TIMER_BASE + 24'd4, 8'(TMR_R));
        tmr_go = 1'b1;
        cpu_write(TIMER_BASE + 24'd6, 8'h01);
        tmr_go = 1'b0;
        wait_irq(2, 4 * TMR_R + 20, "timer 1 interrupt");
        cpu_write(TIMER_BASE + 24'd6, 8'h00); // Stop first, then clear
        clr_go = 1'b1;
        cpu_write(TIMER_BASE + 24'd6, 8'h80);
        clr_go = 1'b0;
        wait_cycles(2);
        tmr_phase = 1'b0;
        end_test("timer period");

        run_copy(16'h1000, 16'h3000, 16, 1'b0);
        end_test("block copy");

        run_copy(16'h1100, 16'h3100, 24, 1'b1);
        end_test("copy with back-pressure");

        cpu_write(CTRL_A, 8'h02);
        assert (!irq[0]) else log_error("copy done still set after clear");
        cpu_write(LEN_A, 8'h00);
        zero_phase = 1'b1;
        cpu_write(CTRL_A, 8'h01);
        wait_irq(0, 10, "empty copy done");
        wait_cycles(3);
        zero_phase  = 1'b0;
        done_clr_go = 1'b1;
        cpu_write(CTRL_A, 8'h02);
        done_clr_go = 1'b0;
        wait_cycles(2);
        end_test("empty copy");

        $display("tests: %0d run, %0d failed, %0d errors", test_num, test_fails, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== minx_soc.f ====
design/minx_pkg.sv
design/reg_decode.sv
design/timer_channel.sv
design/periph_collect.sv
design/copy_engine.sv
design/minx_soc.sv
tests/tb_minx_soc.sv

// ==== Bender.yml ====
package:
  name: minx_soc

sources:
  - design/minx_pkg.sv
  - design/reg_decode.sv
  - design/timer_channel.sv
  - design/periph_collect.sv
  - design/copy_engine.sv
  - design/minx_soc.sv
  - target: test
    files:
      - tests/tb_minx_soc.sv
